// File: bench/rv_exec_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module rv_exec_asserts (
    input logic                   clk_i,
    input logic                   reset_i,
    input logic                   wb_valid_i,
    input rv_exec_pkg::reg_addr_t wb_rd_i,
    input logic                   branch_valid_i,
    input logic                   store_valid_i,
    input logic                   illegal_i
);
    logic [3:0] pulses;

    assign pulses = {wb_valid_i, branch_valid_i, store_valid_i, illegal_i};

    // Flags are cleared by the reset edge
    reset_quiet: assert property (@(posedge clk_i) reset_i |=> pulses == 4'b0000)
        else $error("output pulse while in reset");

    one_pulse: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(pulses))
        else $error("more than one output pulse in a cycle");

    wb_not_x0: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_valid_i |-> wb_rd_i != 5'd0)
        else $error("write-back to x0");

endmodule

bind rv_exec_top rv_exec_asserts u_asserts (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .wb_valid_i     (wb_valid_o),
    .wb_rd_i        (wb_rd_o),
    .branch_valid_i (branch_valid_o),
    .store_valid_i  (store_valid_o),
    .illegal_i      (illegal_o)
);

`default_nettype wire

// File: bench/rv_exec_model.svh
`ifndef RV_EXEC_MODEL_SVH
`define RV_EXEC_MODEL_SVH

// Sign-extended I and S immediates
function automatic xlen_t imm_i_of(input xlen_t ins);
    return {{20{ins[31]}}, ins[31:20]};
endfunction

function automatic xlen_t imm_s_of(input xlen_t ins);
    return {{20{ins[31]}}, ins[31:25], ins[11:7]};
endfunction

// True for encodings of the supported RV32I subset
function automatic logic legal_instr(input xlen_t ins);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       shift_ok;
    f3       = ins[14:12];
    f7       = ins[31:25];
    shift_ok = (f7 == 7'h00) || (f7 == FUNCT7_ALT && f3 == 3'd5);  // SLLI, SRLI, SRAI
    case (ins[6:0])
        OPC_RTYPE:  return f7 == 7'h00 || (f7 == FUNCT7_ALT && (f3 == 3'd0 || f3 == 3'd5));
        OPC_ITYPE:  return (f3 != 3'd1 && f3 != 3'd5) || shift_ok;
        OPC_BRANCH: return f3 == 3'd0 || f3 == 3'd1;  // BEQ, BNE
        OPC_STORE:  return f3 == 3'd2;                // SW
        default:    return 1'b0;
    endcase
endfunction

// Integer operation selected by funct3, bit 30 picks SUB and SRA
function automatic xlen_t arith_result(input xlen_t ins, input xlen_t a, input xlen_t b);
    case (ins[14:12])
        3'd0:    return (ins[6:0] == OPC_RTYPE && ins[30]) ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return ins[30] ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

`endif

// File: bench/rv_exec_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv_exec_tb;
    import rv_exec_pkg::*;

    `include "rv_exec_model.svh"

    typedef struct packed {
        logic [31:0] due;  // Edge count when the pulse is visible
        logic        wb;
        reg_addr_t   rd;
        xlen_t       data;
        logic        branch;
        logic        taken;
        logic        store;
        xlen_t       addr;
        xlen_t       sdata;
        logic        illegal;
    } expect_t;

    logic      clk_i = 1'b0;
    logic      reset_i;
    logic      instr_valid_i;
    xlen_t     instr_i;
    logic      wb_valid_o;
    reg_addr_t wb_rd_o;
    xlen_t     wb_data_o;
    logic      branch_valid_o;
    logic      branch_taken_o;
    logic      store_valid_o;
    xlen_t     store_addr_o;
    xlen_t     store_data_o;
    logic      illegal_o;

    xlen_t   mregs [32];  // Model register file
    expect_t exp_q [$];
    integer  seed           = 32'h023f1f48;
    integer  edge_cnt       = 0;
    integer  value_errors   = 0;
    integer  timeout_errors = 0;
    // ADDI, dependent ADD and SUB, bad SLLI, BLT, SB, LW, then a read of x1
    xlen_t   directed [8]   = '{32'h00500093, 32'h00108133, 32'h401101b3, 32'h40109213,
                                32'h0020c063, 32'h00208023, 32'h0000a083, 32'h000082b3};

    rv_exec_top DUT (.*);

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        edge_cnt <= edge_cnt + 1;
    end

    // Weighted mix of R, I, branch and store encodings plus raw words
    task automatic gen_instr(output xlen_t ins);
        logic [31:0] r;
        logic [31:0] imm;
        logic [2:0]  f3;
        logic [6:0]  f7;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        r   = $random(seed);
        imm = $random(seed);
        f3  = r[6:4];
        rd  = {2'b00, r[9:7]};  // Few registers, many dependencies
        rs1 = {2'b00, r[12:10]};
        rs2 = {2'b00, r[15:13]};
        f7  = (r[16] && (f3 == 3'd0 || f3 == 3'd5)) ? FUNCT7_ALT : 7'h00;
        if (r[20:17] == 4'd0) begin
            f7 = r[27:21];  // Mostly a bad funct7
        end
        if (r[3:0] < 4'd5) begin
            ins = {f7, rs2, rs1, f3, rd, OPC_RTYPE};
        end else if (r[3:0] < 4'd10) begin
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm[11:5] = f7;  // Shift funct7 field
            end
            ins = {imm[11:0], rs1, f3, rd, OPC_ITYPE};
        end else if (r[3:0] < 4'd12) begin
            f3  = (r[20:17] == 4'd0) ? r[6:4] : {2'b00, r[16]};
            ins = {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_BRANCH};
        end else if (r[3:0] < 4'd14) begin
            f3  = (r[20:17] == 4'd0) ? r[6:4] : 3'd2;
            ins = {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
        end else begin
            ins = imm;  // Usually an unknown opcode
        end
    endtask

    // Executes one instruction on the model register file
    task automatic model_exec(input xlen_t ins, output expect_t e);
        xlen_t     a;
        xlen_t     b;
        reg_addr_t rd;
        e     = '0;
        e.due = edge_cnt + 3;  // Sampled next edge, then two stages
        a     = mregs[ins[19:15]];
        b     = mregs[ins[24:20]];
        rd    = ins[11:7];
        if (!legal_instr(ins)) begin
            e.illegal = 1'b1;
        end else if (ins[6:0] == OPC_BRANCH) begin
            e.branch = 1'b1;
            e.taken  = ins[12] ? (a != b) : (a == b);  // BNE or BEQ
        end else if (ins[6:0] == OPC_STORE) begin
            e.store = 1'b1;
            e.addr  = a + imm_s_of(ins);
            e.sdata = b;
        end else if (rd != 5'd0) begin
            e.wb      = 1'b1;
            e.rd      = rd;
            e.data    = arith_result(ins, a, (ins[6:0] == OPC_ITYPE) ? imm_i_of(ins) : b);
            mregs[rd] = e.data;
        end
    endtask

    task automatic issue(input logic valid, input xlen_t ins);
        expect_t e;
        @(posedge clk_i);
        instr_valid_i <= valid;
        instr_i       <= ins;
        if (valid) begin
            model_exec(ins, e);
            exp_q.push_back(e);
        end
    endtask

    task automatic fail_value(input string msg);
        value_errors++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    // Idle cycles and x0 writes expect no pulse at all
    task automatic check_outputs();
        expect_t e;
        e = '0;
        if (exp_q.size() > 0 && exp_q[0].due == edge_cnt) begin
            e = exp_q.pop_front();
        end
        if ({wb_valid_o, branch_valid_o, store_valid_o, illegal_o} !=
            {e.wb, e.branch, e.store, e.illegal}) begin
            fail_value($sformatf("pulses wb/br/st/ill %b%b%b%b, expected %b%b%b%b",
                wb_valid_o, branch_valid_o, store_valid_o, illegal_o,
                e.wb, e.branch, e.store, e.illegal));
        end else if (e.wb && (wb_rd_o != e.rd || wb_data_o != e.data)) begin
            fail_value($sformatf("write-back x%0d=%h, expected x%0d=%h",
                wb_rd_o, wb_data_o, e.rd, e.data));
        end else if (e.branch && branch_taken_o != e.taken) begin
            fail_value($sformatf("branch taken %b, expected %b", branch_taken_o, e.taken));
        end else if (e.store && (store_addr_o != e.addr || store_data_o != e.sdata)) begin
            fail_value($sformatf("store %h <- %h, expected %h <- %h",
                store_addr_o, store_data_o, e.addr, e.sdata));
        end
    endtask

    always @(negedge clk_i) begin
        if (!reset_i) begin
            check_outputs();
        end
    end

    initial begin
        integer      wait_cnt;
        xlen_t       ins;
        logic [31:0] r;
        reset_i       <= 1'b1;
        instr_valid_i <= 1'b0;
        instr_i       <= '0;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;
        foreach (directed[i]) begin
            issue(1'b1, directed[i]);
        end
        for (int n = 0; n < 3000; n++) begin
            gen_instr(ins);
            r = $random(seed);
            issue(r[1:0] != 2'd0, ins);  // Strobe three cycles in four
        end
        // Read back x1..x7 with OR rd, rd, x0
        for (int k = 1; k < 8; k++) begin
            issue(1'b1, {7'h00, 5'd0, k[4:0], 3'd6, k[4:0], OPC_RTYPE});
        end
        issue(1'b0, '0);
        wait_cnt = 0;
        while (exp_q.size() > 0 && wait_cnt < 20) begin
            @(posedge clk_i);
            wait_cnt++;
        end
        if (exp_q.size() > 0) begin
            $display("Timeout: %0d expected results never appeared", exp_q.size());
            timeout_errors++;
        end
        $display("Errors: %0d mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f sources.f --top-module rv_exec_tb -o rv_exec_sim

output=$(./obj_dir/rv_exec_sim 2>&1 || true)
echo "$output"

if grep -qx "Testbench passed" <<< "$output"; then
    exit 0
fi
exit 1

// File: sources.f
+incdir+bench
src/rv_exec_pkg.sv
src/alu_decoder.sv
src/main_decoder.sv
src/operand_fetch.sv
src/alu.sv
src/result_stage.sv
src/rv_exec_top.sv
bench/rv_exec_asserts.sv
bench/rv_exec_tb.sv

// File: src/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  rv_exec_pkg::exec_t exec_i,
    output rv_exec_pkg::xlen_t result_o,
    output logic               zero_o
);
    import rv_exec_pkg::*;

    xlen_t      a;
    xlen_t      b;
    logic [4:0] shamt;

    assign a     = exec_i.op_a;
    assign b     = exec_i.dec.use_imm ? exec_i.dec.imm : exec_i.op_b;
    assign shamt = b[4:0];  // Low 5 bits only

    always_comb begin
        case (exec_i.dec.alu_ctrl)
            ALU_ADD:  result_o = a + b;
            ALU_SUB:  result_o = a - b;
            ALU_SLL:  result_o = a << shamt;
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, a < b};
            ALU_SRL:  result_o = a >> shamt;
            ALU_SRA:  result_o = xlen_t'($signed(a) >>> shamt);
            ALU_OR:   result_o = a | b;
            ALU_XOR:  result_o = a ^ b;
            ALU_AND:  result_o = a & b;
            default:  result_o = '0;  // ALU_ZERO and unused codes
        endcase
    end

    assign zero_o = (result_o == '0);

endmodule

`default_nettype wire

// File: src/alu_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module alu_decoder (
    input  rv_exec_pkg::alu_op_t   alu_op_i,       // Class from main decoder
    input  logic [2:0]             funct3_i,
    input  logic [6:0]             funct7_i,
    output rv_exec_pkg::alu_ctrl_t alu_control_o,
    output logic                   illegal_o       // Bad funct7 for this funct3
);
    import rv_exec_pkg::*;

    always_comb begin
        alu_control_o = ALU_ZERO;
        illegal_o     = 1'b0;
        case (alu_op_i)
            ALU_OP_ITYPE: begin
                case (funct3_i)
                    3'h0: alu_control_o = ALU_ADD;   // ADDI
                    3'h2: alu_control_o = ALU_SLT;   // SLTI
                    3'h3: alu_control_o = ALU_SLTU;  // SLTIU
                    3'h4: alu_control_o = ALU_XOR;
                    3'h6: alu_control_o = ALU_OR;
                    3'h7: alu_control_o = ALU_AND;
                    3'h1: begin
                        if (funct7_i == 7'h00) begin
                            alu_control_o = ALU_SLL;  // SLLI
                        end else begin
                            illegal_o = 1'b1;
                        end
                    end
                    3'h5: begin
                        case (funct7_i)
                            7'h00:      alu_control_o = ALU_SRL;  // SRLI
                            FUNCT7_ALT: alu_control_o = ALU_SRA;  // SRAI
                            default:    illegal_o = 1'b1;
                        endcase
                    end
                endcase
            end
            ALU_OP_BRANCH: alu_control_o = ALU_SUB;  // Equality via zero flag
            ALU_OP_RTYPE: begin
                if (funct7_i == 7'h00) begin
                    case (funct3_i)
                        3'h0: alu_control_o = ALU_ADD;
                        3'h1: alu_control_o = ALU_SLL;
                        3'h2: alu_control_o = ALU_SLT;
                        3'h3: alu_control_o = ALU_SLTU;
                        3'h4: alu_control_o = ALU_XOR;
                        3'h5: alu_control_o = ALU_SRL;
                        3'h6: alu_control_o = ALU_OR;
                        3'h7: alu_control_o = ALU_AND;
                    endcase
                end else if (funct7_i == FUNCT7_ALT && funct3_i == 3'h0) begin
                    alu_control_o = ALU_SUB;
                end else if (funct7_i == FUNCT7_ALT && funct3_i == 3'h5) begin
                    alu_control_o = ALU_SRA;
                end else begin
                    illegal_o = 1'b1;  // Result stays ALU_ZERO
                end
            end
            default: alu_control_o = ALU_ADD;  // Store address rs1 + imm
        endcase
    end

endmodule

`default_nettype wire

// File: src/main_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module main_decoder (
    input  rv_exec_pkg::xlen_t   instr_i,
    input  logic                 instr_valid_i,
    output rv_exec_pkg::decode_t decode_o
);
    import rv_exec_pkg::*;

    opcode_t   opcode;
    funct3_t   funct3;
    alu_op_t   alu_op;
    alu_ctrl_t alu_ctrl;
    logic      alu_illegal;
    logic      opc_illegal;
    xlen_t     imm_i;
    xlen_t     imm_s;
    xlen_t     imm_b;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};

    alu_decoder u_alu_decoder (
        .alu_op_i      (alu_op),
        .funct3_i      (funct3),
        .funct7_i      (instr_i[31:25]),
        .alu_control_o (alu_ctrl),
        .illegal_o     (alu_illegal)
    );

    // Opcode class and funct3 legality
    always_comb begin
        alu_op      = ALU_OP_ITYPE;
        opc_illegal = 1'b0;
        case (opcode)
            OPC_RTYPE:  alu_op = ALU_OP_RTYPE;
            OPC_ITYPE:  alu_op = ALU_OP_ITYPE;
            OPC_BRANCH: begin
                alu_op      = ALU_OP_BRANCH;
                opc_illegal = (funct3 != F3_BEQ) && (funct3 != F3_BNE);
            end
            OPC_STORE: begin
                alu_op      = ALU_OP_STORE;
                opc_illegal = (funct3 != F3_SW);  // Only SW
            end
            default: opc_illegal = 1'b1;
        endcase
    end

    always_comb begin
        decode_o          = '0;
        decode_o.valid    = instr_valid_i;
        decode_o.alu_ctrl = alu_ctrl;
        decode_o.rs1      = instr_i[19:15];
        decode_o.rs2      = instr_i[24:20];
        decode_o.rd       = instr_i[11:7];
        decode_o.illegal  = opc_illegal | alu_illegal;
        case (opcode)
            OPC_RTYPE: decode_o.reg_we = 1'b1;
            OPC_ITYPE: begin
                decode_o.use_imm = 1'b1;
                decode_o.reg_we  = 1'b1;
                decode_o.imm     = imm_i;
            end
            OPC_BRANCH: begin
                decode_o.is_branch = 1'b1;
                decode_o.branch_ne = (funct3 == F3_BNE);
                decode_o.imm       = imm_b;  // Target not used here
            end
            OPC_STORE: begin
                decode_o.is_store = 1'b1;
                decode_o.use_imm  = 1'b1;
                decode_o.imm      = imm_s;
            end
            default: decode_o.imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/operand_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module operand_fetch (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  rv_exec_pkg::decode_t   decode_i,
    input  logic                   wb_we_i,
    input  rv_exec_pkg::reg_addr_t wb_rd_i,
    input  rv_exec_pkg::xlen_t     wb_data_i,
    output rv_exec_pkg::exec_t     exec_o
);
    import rv_exec_pkg::*;

    xlen_t regs [1:31];  // x0 is not stored
    exec_t exec_d;
    exec_t exec_q;

    function automatic logic wb_hit(input logic we, input reg_addr_t wr, input reg_addr_t rs);
        return we && (wr == rs) && (rs != '0);
    endfunction

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // Read side, write at the same edge is bypassed
    always_comb begin
        exec_d.dec  = decode_i;
        exec_d.op_a = (decode_i.rs1 == '0) ? '0 : regs[decode_i.rs1];
        exec_d.op_b = (decode_i.rs2 == '0) ? '0 : regs[decode_i.rs2];
        if (wb_hit(wb_we_i, wb_rd_i, decode_i.rs1)) begin
            exec_d.op_a = wb_data_i;
        end
        if (wb_hit(wb_we_i, wb_rd_i, decode_i.rs2)) begin
            exec_d.op_b = wb_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        exec_q <= exec_d;
        if (reset_i) begin
            exec_q.dec.valid <= 1'b0;
        end
    end

    // Result of the instruction just ahead replaces stale operands
    always_comb begin
        exec_o = exec_q;
        if (wb_hit(wb_we_i, wb_rd_i, exec_q.dec.rs1)) begin
            exec_o.op_a = wb_data_i;
        end
        if (wb_hit(wb_we_i, wb_rd_i, exec_q.dec.rs2)) begin
            exec_o.op_b = wb_data_i;
        end
    end

endmodule

`default_nettype wire

// File: src/result_stage.sv
`timescale 1ns/100ps
`default_nettype none

module result_stage (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  rv_exec_pkg::exec_t   exec_i,
    input  rv_exec_pkg::xlen_t   alu_result_i,
    input  logic                 zero_i,
    output rv_exec_pkg::result_t result_o
);
    import rv_exec_pkg::*;

    result_t res_q;
    logic    legal;

    assign legal = exec_i.dec.valid && !exec_i.dec.illegal;

    always_ff @(posedge clk_i) begin
        res_q.rd         <= exec_i.dec.rd;
        res_q.result     <= alu_result_i;  // Also the store address
        res_q.taken      <= exec_i.dec.branch_ne ? !zero_i : zero_i;
        res_q.store_data <= exec_i.op_b;
        if (reset_i) begin
            res_q.valid   <= 1'b0;
            res_q.reg_we  <= 1'b0;
            res_q.branch  <= 1'b0;
            res_q.store   <= 1'b0;
            res_q.illegal <= 1'b0;
        end else begin
            res_q.valid   <= exec_i.dec.valid;
            res_q.reg_we  <= legal && exec_i.dec.reg_we && (exec_i.dec.rd != '0);  // No x0 write
            res_q.branch  <= legal && exec_i.dec.is_branch;
            res_q.store   <= legal && exec_i.dec.is_store;
            res_q.illegal <= exec_i.dec.valid && exec_i.dec.illegal;
        end
    end

    assign result_o = res_q;

endmodule

`default_nettype wire

// File: src/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;      // Data word
    typedef logic [4:0]      reg_addr_t;  // Register index
    typedef logic [1:0]      alu_op_t;    // Class from main decoder
    typedef logic [3:0]      alu_ctrl_t;  // ALU control code
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;

    localparam alu_op_t ALU_OP_ITYPE  = 2'd0;
    localparam alu_op_t ALU_OP_BRANCH = 2'd1;
    localparam alu_op_t ALU_OP_RTYPE  = 2'd2;
    localparam alu_op_t ALU_OP_STORE  = 2'd3;

    localparam alu_ctrl_t ALU_ADD  = 4'h0;
    localparam alu_ctrl_t ALU_SUB  = 4'h1;
    localparam alu_ctrl_t ALU_SLL  = 4'h2;
    localparam alu_ctrl_t ALU_SLT  = 4'h3;
    localparam alu_ctrl_t ALU_SLTU = 4'h4;
    localparam alu_ctrl_t ALU_SRL  = 4'h5;
    localparam alu_ctrl_t ALU_SRA  = 4'h6;
    localparam alu_ctrl_t ALU_OR   = 4'h7;
    localparam alu_ctrl_t ALU_XOR  = 4'h8;
    localparam alu_ctrl_t ALU_AND  = 4'h9;
    localparam alu_ctrl_t ALU_ZERO = 4'hA;  // Result forced to 0

    localparam opcode_t OPC_RTYPE  = 7'b0110011;
    localparam opcode_t OPC_ITYPE  = 7'b0010011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    localparam logic [6:0] FUNCT7_ALT = 7'h20;  // SUB and SRA

    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;

    typedef struct packed {
        logic      valid;
        alu_ctrl_t alu_ctrl;
        logic      use_imm;
        xlen_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      reg_we;
        logic      is_branch;
        logic      branch_ne;
        logic      is_store;
        logic      illegal;
    } decode_t;

    typedef struct packed {
        decode_t dec;
        xlen_t   op_a;  // rs1 value
        xlen_t   op_b;  // rs2 value
    } exec_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      reg_we;
        xlen_t     result;  // Write-back data or store address
        logic      branch;
        logic      taken;
        logic      store;
        xlen_t     store_data;
        logic      illegal;
    } result_t;

endpackage

`default_nettype wire

// File: src/rv_exec_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_exec_top (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   instr_valid_i,   // One-cycle strobe
    input  rv_exec_pkg::xlen_t     instr_i,
    output logic                   wb_valid_o,
    output rv_exec_pkg::reg_addr_t wb_rd_o,
    output rv_exec_pkg::xlen_t     wb_data_o,
    output logic                   branch_valid_o,
    output logic                   branch_taken_o,
    output logic                   store_valid_o,
    output rv_exec_pkg::xlen_t     store_addr_o,
    output rv_exec_pkg::xlen_t     store_data_o,
    output logic                   illegal_o
);
    import rv_exec_pkg::*;

    decode_t dec;
    exec_t   exec;
    xlen_t   alu_result;
    logic    alu_zero;
    result_t res;

    main_decoder u_main_decoder (
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .decode_o      (dec)
    );

    operand_fetch u_operand_fetch (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .decode_i  (dec),
        .wb_we_i   (res.reg_we),
        .wb_rd_i   (res.rd),
        .wb_data_i (res.result),
        .exec_o    (exec)
    );

    alu u_alu (
        .exec_i   (exec),
        .result_o (alu_result),
        .zero_o   (alu_zero)
    );

    result_stage u_result_stage (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .exec_i       (exec),
        .alu_result_i (alu_result),
        .zero_i       (alu_zero),
        .result_o     (res)
    );

    assign wb_valid_o     = res.reg_we;
    assign wb_rd_o        = res.rd;
    assign wb_data_o      = res.result;
    assign branch_valid_o = res.branch;
    assign branch_taken_o = res.taken;
    assign store_valid_o  = res.store;
    assign store_addr_o   = res.result;
    assign store_data_o   = res.store_data;
    assign illegal_o      = res.illegal;

endmodule

`default_nettype wire
